// File: run_sim.sh
#!/bin/sh
# build and run the wb_top testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f wb_commit.f --top-module wb_top_tb -o wb_top_sim

./obj_dir/wb_top_sim > sim.log 2>&1 || {
    cat sim.log
    echo "simulation exited with an error"
    exit 1
}
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation reported no failures"

// File: src/div_unit.sv
`include "wb_defs.svh"
`timescale 1ns/10ps

module div_unit (
    input  logic          clk,
    input  logic          aresetn,
    input  logic          div_start,
    input  wb_pkg::word_t div_dividend,
    input  wb_pkg::word_t div_divisor,
    output wb_pkg::word_t quotient,
    output wb_pkg::word_t remainder,
    output logic          div_ready
);

    wb_pkg::div_state_t          state;
    wb_pkg::word_t               quo;
    wb_pkg::word_t               rem;
    wb_pkg::word_t               dvsr;
    logic [$clog2(`WB_XLEN)-1:0] count;
    logic [`WB_XLEN:0]           trial;
    logic [`WB_XLEN:0]           diff;
    logic                        load;

    assign load = (state == wb_pkg::DIV_IDLE) && div_start;

    // next partial remainder and its trial subtraction
    assign trial = {rem, quo[`WB_XLEN-1]};
    assign diff  = trial - {1'b0, dvsr};

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state <= wb_pkg::DIV_IDLE;
            count <= '0;
        end else begin
            case (state)
                wb_pkg::DIV_IDLE: begin
                    if (div_start) begin
                        state <= wb_pkg::DIV_RUN;
                        count <= '0;
                    end
                end
                wb_pkg::DIV_RUN: begin
                    count <= count + 1'b1;
                    // last quotient bit this cycle
                    if (count == '1) begin
                        state <= wb_pkg::DIV_DONE;
                    end
                end
                wb_pkg::DIV_DONE: begin
                    state <= wb_pkg::DIV_IDLE;
                end
                default: begin
                    state <= wb_pkg::DIV_IDLE;
                end
            endcase
        end
    end

    // dividend shifts out of quo while quotient bits shift in
    always_ff @(posedge clk) begin
        if (load) begin
            quo  <= div_dividend;
            rem  <= '0;
            dvsr <= div_divisor;
        end else if (state == wb_pkg::DIV_RUN) begin
            if (!diff[`WB_XLEN]) begin
                rem <= diff[`WB_XLEN-1:0];
                quo <= {quo[`WB_XLEN-2:0], 1'b1};
            end else begin
                rem <= trial[`WB_XLEN-1:0];
                quo <= {quo[`WB_XLEN-2:0], 1'b0};
            end
        end
    end

    // zero divisor falls out naturally as all ones and the dividend
    assign quotient  = quo;
    assign remainder = rem;
    assign div_ready = (state == wb_pkg::DIV_DONE);

endmodule

// File: src/regfile.sv
`include "wb_defs.svh"
`timescale 1ns/10ps

module regfile (
    input  logic             clk,
    input  logic             aresetn,
    input  logic             we0,
    input  logic             we1,
    input  wb_pkg::reg_idx_t waddr0,
    input  wb_pkg::reg_idx_t waddr1,
    input  wb_pkg::word_t    wdata0,
    input  wb_pkg::word_t    wdata1,
    input  wb_pkg::reg_idx_t raddr0,
    input  wb_pkg::reg_idx_t raddr1,
    output wb_pkg::word_t    rdata0,
    output wb_pkg::word_t    rdata1
);

    wb_pkg::word_t regs [1 << `WB_REG_BITS];

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < (1 << `WB_REG_BITS); i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0 && (waddr0 != '0)) begin
                regs[waddr0] <= wdata0;
            end
            // lane 1 is younger, so it overrides lane 0
            if (we1 && (waddr1 != '0)) begin
                regs[waddr1] <= wdata1;
            end
        end
    end

    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];

endmodule

// File: src/wb_defs.svh
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// widths
`define WB_XLEN       32
`define WB_REG_BITS   5
`define WB_UOP_BITS   6
`define WB_ECODE_BITS 7
`define WB_VPPN_BITS  19

// uop bit positions
`define UOP_INS_ALU    0
`define UOP_INS_CSR    1
`define UOP_INS_DIV    2
`define UOP_INS_MEM    3
// remainder instead of quotient
`define UOP_COND_REM   4
// store instead of load
`define UOP_COND_STORE 5

// exception codes, LoongArch encoding
`define EXP_INT  7'h00
`define EXP_PIL  7'h01
`define EXP_PIS  7'h02
`define EXP_PIF  7'h03
`define EXP_PME  7'h04
`define EXP_PPI  7'h07
`define EXP_ADEF 7'h08
`define EXP_ALE  7'h09
`define EXP_SYS  7'h0b
`define EXP_TLBR 7'h3f

`endif

// File: src/wb_exception.sv
`include "wb_defs.svh"
`timescale 1ns/10ps

module wb_exception (
    input  logic           clk,
    input  logic           aresetn,
    input  logic           exception_flag,
    input  logic           cpu_interrupt,
    input  wb_pkg::ecode_t ecode,
    input  wb_pkg::word_t  badv,
    input  wb_pkg::word_t  era,
    input  wb_pkg::word_t  eentry,
    input  wb_pkg::word_t  tlbrentry,
    output logic           flush,
    output logic           wen_badv,
    output logic           wen_era,
    output logic           wen_vppn,
    output logic           tlb_exception,
    output wb_pkg::word_t  badv_out,
    output wb_pkg::word_t  era_out,
    output wb_pkg::word_t  pc_from_wb,
    output wb_pkg::vppn_t  vppn_out
);

    logic set_badv;
    logic set_vppn;

    // which csrs this ecode updates
    always_comb begin
        set_badv = 1'b0;
        set_vppn = 1'b0;
        case (ecode)
            `EXP_PIL, `EXP_PIS, `EXP_PIF, `EXP_PME, `EXP_PPI, `EXP_TLBR: begin
                set_badv = 1'b1;
                set_vppn = 1'b1;
            end
            `EXP_ADEF, `EXP_ALE: begin
                set_badv = 1'b1;
            end
            default: begin
                set_badv = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            flush         <= 1'b0;
            wen_era       <= 1'b0;
            wen_badv      <= 1'b0;
            wen_vppn      <= 1'b0;
            tlb_exception <= 1'b0;
        end else begin
            flush         <= exception_flag || cpu_interrupt;
            wen_era       <= exception_flag || cpu_interrupt;
            wen_badv      <= exception_flag && set_badv;
            wen_vppn      <= exception_flag && set_vppn;
            tlb_exception <= exception_flag && (ecode == `EXP_TLBR);
        end
    end

    always_ff @(posedge clk) begin
        badv_out <= badv;
        era_out  <= era;
        vppn_out <= badv[`WB_VPPN_BITS-1:0];
    end

    // tlb refill goes to its own handler
    assign pc_from_wb = tlb_exception ? tlbrentry : eentry;

endmodule

// File: src/wb_pkg.sv
`include "wb_defs.svh"

package wb_pkg;

    // data or pc word
    typedef logic [`WB_XLEN-1:0] word_t;

    // architectural register number
    typedef logic [`WB_REG_BITS-1:0] reg_idx_t;

    typedef logic [`WB_UOP_BITS-1:0] uop_t;

    typedef logic [`WB_ECODE_BITS-1:0] ecode_t;

    // bad address bits for the tlb entry-high csr
    typedef logic [`WB_VPPN_BITS-1:0] vppn_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage

// File: src/wb_select.sv
`include "wb_defs.svh"
`timescale 1ns/10ps

module wb_select (
    input  logic             clk,
    input  logic             aresetn,
    input  wb_pkg::word_t    inst0,
    input  wb_pkg::word_t    inst1,
    input  wb_pkg::uop_t     uop0,
    input  wb_pkg::uop_t     uop1,
    input  wb_pkg::reg_idx_t rd0,
    input  wb_pkg::reg_idx_t rd1,
    input  wb_pkg::word_t    result0,
    input  wb_pkg::word_t    result1,
    input  logic             result0_valid,
    input  logic             result1_valid,
    input  wb_pkg::word_t    quotient,
    input  wb_pkg::word_t    remainder,
    input  logic             div_ready,
    input  wb_pkg::word_t    dcache_data,
    input  logic             dcache_ready,
    input  logic             tlb_d_valid,
    input  wb_pkg::word_t    csr_data,
    input  logic             csr_ready,
    output logic             ex2_allowin,
    output logic             wb_we0,
    output logic             wb_we1,
    output wb_pkg::reg_idx_t wb_rd0,
    output wb_pkg::reg_idx_t wb_rd1,
    output wb_pkg::word_t    wb_data0,
    output wb_pkg::word_t    wb_data1
);

    // {we, data} chosen for each lane
    logic [`WB_XLEN:0] pick0;
    logic [`WB_XLEN:0] pick1;
    logic              stage_empty;
    logic              load_wait;

    // priority: alu result, csr, divider, load
    function automatic logic [`WB_XLEN:0] lane_pick(
        input logic          res_valid,
        input wb_pkg::word_t res,
        input wb_pkg::uop_t  uop,
        input logic          csr_en
    );
        logic [`WB_XLEN:0] pick;
        pick = '0;
        if (res_valid) begin
            pick = {1'b1, res};
        end else if (csr_en && uop[`UOP_INS_CSR]) begin
            pick = {csr_ready, csr_data};
        end else if (uop[`UOP_INS_DIV]) begin
            pick = {div_ready, (uop[`UOP_COND_REM] ? remainder : quotient)};
        end else if (uop[`UOP_INS_MEM] && !uop[`UOP_COND_STORE]) begin
            pick = {dcache_ready, dcache_data};
        end
        return pick;
    endfunction

    always_comb begin
        // only lane 0 may carry a csr read
        pick0 = lane_pick(result0_valid, result0, uop0, 1'b1);
        pick1 = lane_pick(result1_valid, result1, uop1, 1'b0);
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            wb_we0 <= 1'b0;
            wb_we1 <= 1'b0;
        end else begin
            wb_we0 <= pick0[`WB_XLEN];
            wb_we1 <= pick1[`WB_XLEN];
        end
    end

    always_ff @(posedge clk) begin
        wb_data0 <= pick0[`WB_XLEN-1:0];
        wb_data1 <= pick1[`WB_XLEN-1:0];
        wb_rd0   <= rd0;
        wb_rd1   <= rd1;
    end

    // stage accept for ex1
    assign stage_empty = (inst0 == '0) && (inst1 == '0);
    assign load_wait   = tlb_d_valid && !dcache_ready;

    assign ex2_allowin = stage_empty || !load_wait || div_ready || csr_ready;

endmodule

// File: src/wb_top.sv
`include "wb_defs.svh"
`timescale 1ns/10ps

module wb_top (
    input  logic             clk,
    input  logic             aresetn,
    input  wb_pkg::word_t    pc0,
    input  wb_pkg::word_t    pc1,
    input  wb_pkg::word_t    inst0,
    input  wb_pkg::word_t    inst1,
    input  wb_pkg::uop_t     uop0,
    input  wb_pkg::uop_t     uop1,
    input  wb_pkg::reg_idx_t rd0,
    input  wb_pkg::reg_idx_t rd1,
    input  wb_pkg::word_t    result0,
    input  wb_pkg::word_t    result1,
    input  logic             result0_valid,
    input  logic             result1_valid,
    input  wb_pkg::word_t    dcache_data,
    input  logic             dcache_ready,
    input  logic             tlb_d_valid,
    input  wb_pkg::word_t    csr_data,
    input  logic             csr_ready,
    input  logic             div_start,
    input  wb_pkg::word_t    div_dividend,
    input  wb_pkg::word_t    div_divisor,
    input  logic             exception_flag,
    input  wb_pkg::ecode_t   ecode,
    input  wb_pkg::word_t    badv,
    input  wb_pkg::word_t    era,
    input  logic             cpu_interrupt,
    input  wb_pkg::word_t    eentry,
    input  wb_pkg::word_t    tlbrentry,
    input  wb_pkg::reg_idx_t rf_raddr0,
    input  wb_pkg::reg_idx_t rf_raddr1,
    output logic             ex2_allowin,
    output logic             wb_we0,
    output logic             wb_we1,
    output wb_pkg::reg_idx_t wb_rd0,
    output wb_pkg::reg_idx_t wb_rd1,
    output wb_pkg::word_t    wb_data0,
    output wb_pkg::word_t    wb_data1,
    output wb_pkg::word_t    rf_rdata0,
    output wb_pkg::word_t    rf_rdata1,
    output logic             flush,
    output wb_pkg::word_t    pc_from_wb,
    output logic             wen_badv,
    output wb_pkg::word_t    badv_out,
    output logic             wen_era,
    output wb_pkg::word_t    era_out,
    output logic             wen_vppn,
    output wb_pkg::vppn_t    vppn_out,
    output logic             tlb_exception
);

    wb_pkg::word_t quotient;
    wb_pkg::word_t remainder;
    logic          div_ready;

    div_unit div_unit_i (
        .clk          (clk),
        .aresetn      (aresetn),
        .div_start    (div_start),
        .div_dividend (div_dividend),
        .div_divisor  (div_divisor),
        .quotient     (quotient),
        .remainder    (remainder),
        .div_ready    (div_ready)
    );

    wb_select wb_select_i (
        .clk           (clk),
        .aresetn       (aresetn),
        .inst0         (inst0),
        .inst1         (inst1),
        .uop0          (uop0),
        .uop1          (uop1),
        .rd0           (rd0),
        .rd1           (rd1),
        .result0       (result0),
        .result1       (result1),
        .result0_valid (result0_valid),
        .result1_valid (result1_valid),
        .quotient      (quotient),
        .remainder     (remainder),
        .div_ready     (div_ready),
        .dcache_data   (dcache_data),
        .dcache_ready  (dcache_ready),
        .tlb_d_valid   (tlb_d_valid),
        .csr_data      (csr_data),
        .csr_ready     (csr_ready),
        .ex2_allowin   (ex2_allowin),
        .wb_we0        (wb_we0),
        .wb_we1        (wb_we1),
        .wb_rd0        (wb_rd0),
        .wb_rd1        (wb_rd1),
        .wb_data0      (wb_data0),
        .wb_data1      (wb_data1)
    );

    wb_exception wb_exception_i (
        .clk            (clk),
        .aresetn        (aresetn),
        .exception_flag (exception_flag),
        .cpu_interrupt  (cpu_interrupt),
        .ecode          (ecode),
        .badv           (badv),
        .era            (era),
        .eentry         (eentry),
        .tlbrentry      (tlbrentry),
        .flush          (flush),
        .wen_badv       (wen_badv),
        .wen_era        (wen_era),
        .wen_vppn       (wen_vppn),
        .tlb_exception  (tlb_exception),
        .badv_out       (badv_out),
        .era_out        (era_out),
        .pc_from_wb     (pc_from_wb),
        .vppn_out       (vppn_out)
    );

    regfile regfile_i (
        .clk     (clk),
        .aresetn (aresetn),
        .we0     (wb_we0),
        .we1     (wb_we1),
        .waddr0  (wb_rd0),
        .waddr1  (wb_rd1),
        .wdata0  (wb_data0),
        .wdata1  (wb_data1),
        .raddr0  (rf_raddr0),
        .raddr1  (rf_raddr1),
        .rdata0  (rf_rdata0),
        .rdata1  (rf_rdata1)
    );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    // 8 ns period
    localparam int HALF_PERIOD = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

// File: tests/wb_top_properties.sv
`timescale 1ns/10ps

module wb_top_properties (
    input logic clk,
    input logic aresetn,
    input logic we0,
    input logic we1,
    input logic div_ready,
    input logic flush,
    input logic wen_badv,
    input logic wen_vppn,
    input logic tlb_exception
);

    // nothing is written back while reset is held
    quiet_in_reset: assert property (@(posedge clk) !aresetn |-> !we0 && !we1 && !flush)
        else $error("write strobe or flush while in reset");

    single_ready: assert property (@(posedge clk) disable iff (!aresetn)
        div_ready |=> !div_ready)
        else $error("div_ready high for two cycles in a row");

    // vppn codes are a subset of badv codes, refill a subset of vppn codes
    vppn_has_badv: assert property (@(posedge clk) disable iff (!aresetn)
        wen_vppn |-> wen_badv)
        else $error("wen_vppn without wen_badv");

    refill_has_vppn: assert property (@(posedge clk) disable iff (!aresetn)
        tlb_exception |-> wen_vppn)
        else $error("tlb_exception without wen_vppn");

endmodule

bind wb_select wb_top_properties select_props_i (
    .clk, .aresetn, .we0(wb_we0), .we1(wb_we1), .div_ready,
    .flush(1'b0), .wen_badv(1'b0), .wen_vppn(1'b0), .tlb_exception(1'b0)
);

bind wb_exception wb_top_properties exception_props_i (
    .clk, .aresetn, .we0(1'b0), .we1(1'b0), .div_ready(1'b0),
    .flush, .wen_badv, .wen_vppn, .tlb_exception
);

// File: tests/wb_top_tb.sv
`include "wb_defs.svh"
`timescale 1ns/10ps

module wb_top_tb;

    localparam int unsigned SEED       = 32'h9e0a_1e17;
    localparam int          WAIT_MAX   = 64;
    localparam int          DIV_CYCLES = 33;

    logic             clk, aresetn;
    wb_pkg::word_t    pc0, pc1, inst0, inst1, result0, result1;
    wb_pkg::uop_t     uop0, uop1;
    wb_pkg::reg_idx_t rd0, rd1, rf_raddr0, rf_raddr1;
    logic             result0_valid, result1_valid;
    wb_pkg::word_t    dcache_data, csr_data, div_dividend, div_divisor;
    logic             dcache_ready, tlb_d_valid, csr_ready, div_start;
    logic             exception_flag, cpu_interrupt;
    wb_pkg::ecode_t   ecode;
    wb_pkg::word_t    badv, era, eentry, tlbrentry;
    logic             ex2_allowin, wb_we0, wb_we1;
    wb_pkg::reg_idx_t wb_rd0, wb_rd1;
    wb_pkg::word_t    wb_data0, wb_data1, rf_rdata0, rf_rdata1;
    logic             flush, wen_badv, wen_era, wen_vppn, tlb_exception;
    wb_pkg::word_t    pc_from_wb, badv_out, era_out;
    wb_pkg::vppn_t    vppn_out;
    int               errors;
    int               checks;

    tb_clock tb_clock_i (.clk(clk));

    wb_top wb_top_i (.*);

    task automatic check_value(input string name, input wb_pkg::word_t expected,
                               input wb_pkg::word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // empty stage with nothing pending
    task automatic clear_lanes();
        pc0 = '0;
        pc1 = '0;
        inst0 = '0;
        inst1 = '0;
        uop0 = '0;
        uop1 = '0;
        rd0 = '0;
        rd1 = '0;
        result0 = '0;
        result1 = '0;
        result0_valid = 1'b0;
        result1_valid = 1'b0;
        dcache_ready = 1'b0;
        tlb_d_valid = 1'b0;
        csr_ready = 1'b0;
        div_start = 1'b0;
        exception_flag = 1'b0;
        cpu_interrupt = 1'b0;
    endtask

    task automatic wait_div_ready(input string name, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (!wb_top_i.div_ready && ex2_allowin) begin
                errors++;
                $display("%s: ex2_allowin high while a load waits on the divider", name);
            end
        end while (!wb_top_i.div_ready && cycles < WAIT_MAX);
        if (!wb_top_i.div_ready) begin
            errors++;
            $display("%s: div_ready did not rise within %0d cycles", name, WAIT_MAX);
        end
    endtask

    task automatic wait_lane0_strobe(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_we0 && cycles < WAIT_MAX);
        if (!wb_we0) begin
            errors++;
            $display("%s: no lane 0 write strobe within %0d cycles", name, WAIT_MAX);
        end
    endtask

    // both lanes carry a valid result that is read back two edges later
    task automatic issue_pair(input string name, input wb_pkg::uop_t u0, input wb_pkg::uop_t u1,
                              input wb_pkg::reg_idx_t ra, input wb_pkg::reg_idx_t rb,
                              input wb_pkg::word_t da, input wb_pkg::word_t db,
                              input wb_pkg::word_t exp0, input wb_pkg::word_t exp1);
        inst0 = $urandom | 1;
        inst1 = $urandom | 1;
        uop0 = u0;
        uop1 = u1;
        rd0 = ra;
        rd1 = rb;
        result0 = da;
        result1 = db;
        result0_valid = 1'b1;
        result1_valid = 1'b1;
        rf_raddr0 = ra;
        rf_raddr1 = rb;
        @(negedge clk);
        check_value({name, " wb_we0"}, 32'd1, wb_we0);
        check_value({name, " wb_we1"}, 32'd1, wb_we1);
        check_value({name, " wb_rd0"}, ra, wb_rd0);
        check_value({name, " wb_rd1"}, rb, wb_rd1);
        check_value({name, " wb_data0"}, da, wb_data0);
        check_value({name, " wb_data1"}, db, wb_data1);
        clear_lanes();
        @(negedge clk);
        check_value({name, " rf_rdata0"}, exp0, rf_rdata0);
        check_value({name, " rf_rdata1"}, exp1, rf_rdata1);
    endtask

    task automatic alu_writeback();
        wb_pkg::uop_t     alu;
        wb_pkg::reg_idx_t ra;
        wb_pkg::word_t    da;
        wb_pkg::word_t    db;
        alu = wb_pkg::uop_t'(1 << `UOP_INS_ALU);
        repeat (4) begin
            ra = wb_pkg::reg_idx_t'(1 + $urandom % 31);
            da = $urandom;
            db = $urandom;
            issue_pair("alu", alu, alu, ra, wb_pkg::reg_idx_t'(ra % 31 + 1), da, db, da, db);
        end
        da = $urandom;
        db = $urandom;
        issue_pair("alu r0", alu, alu, 5'd0, 5'd7, da, db, 32'd0, db);
        // younger lane wins on the same register
        issue_pair("alu same rd", alu, alu, 5'd9, 5'd9, da, db, db, db);
    endtask

    // lane 0 wants the quotient and lane 1 the remainder
    task automatic run_division(input string name, input wb_pkg::word_t dividend,
                                input wb_pkg::word_t divisor);
        wb_pkg::word_t    exp_q;
        wb_pkg::word_t    exp_r;
        wb_pkg::reg_idx_t rd_q;
        wb_pkg::reg_idx_t rd_r;
        int               cycles;
        exp_q = (divisor == 0) ? '1 : dividend / divisor;
        exp_r = (divisor == 0) ? dividend : dividend % divisor;
        rd_q = wb_pkg::reg_idx_t'(1 + $urandom % 31);
        rd_r = wb_pkg::reg_idx_t'(rd_q % 31 + 1);
        div_dividend = dividend;
        div_divisor = divisor;
        div_start = 1'b1;
        inst0 = $urandom | 1;
        inst1 = $urandom | 1;
        uop0 = wb_pkg::uop_t'(1 << `UOP_INS_DIV);
        uop1 = wb_pkg::uop_t'((1 << `UOP_INS_DIV) | (1 << `UOP_COND_REM));
        rd0 = rd_q;
        rd1 = rd_r;
        tlb_d_valid = 1'b1;
        rf_raddr0 = rd_q;
        rf_raddr1 = rd_r;
        @(negedge clk);
        div_start = 1'b0;
        check_value({name, " allowin busy"}, 32'd0, ex2_allowin);
        wait_div_ready(name, cycles);
        check_value({name, " latency"}, DIV_CYCLES, cycles + 1);
        check_value({name, " allowin ready"}, 32'd1, ex2_allowin);
        @(negedge clk);
        check_value({name, " wb_we0"}, 32'd1, wb_we0);
        check_value({name, " wb_we1"}, 32'd1, wb_we1);
        clear_lanes();
        @(negedge clk);
        check_value({name, " quotient"}, exp_q, rf_rdata0);
        check_value({name, " remainder"}, exp_r, rf_rdata1);
    endtask

    task automatic division();
        wb_pkg::word_t a;
        a = $urandom;
        run_division("div random", a, $urandom >> ($urandom % 32));
        run_division("div small", $urandom % 1000, $urandom | 32'h8000_0000);
        run_division("div zero", a, '0);
        run_division("div by one", a, 32'd1);
    endtask

    task automatic load_and_csr();
        wb_pkg::word_t    data;
        wb_pkg::reg_idx_t rd_c;
        // empty stage accepts even with a load outstanding
        tlb_d_valid = 1'b1;
        @(negedge clk);
        check_value("empty allowin", 32'd1, ex2_allowin);
        data = $urandom;
        rd_c = 5'd21;
        inst0 = $urandom | 1;
        uop0 = wb_pkg::uop_t'(1 << `UOP_INS_MEM);
        rd0 = 5'd20;
        rf_raddr0 = 5'd20;
        dcache_data = data;
        tlb_d_valid = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("load stall wb_we0", 32'd0, wb_we0);
            check_value("load stall allowin", 32'd0, ex2_allowin);
        end
        dcache_ready = 1'b1;
        wait_lane0_strobe("load");
        check_value("load wb_data0", data, wb_data0);
        clear_lanes();
        @(negedge clk);
        check_value("load readback", data, rf_rdata0);
        // csr read waits for csr_ready
        data = $urandom;
        inst0 = $urandom | 1;
        uop0 = wb_pkg::uop_t'(1 << `UOP_INS_CSR);
        rd0 = rd_c;
        rf_raddr0 = rd_c;
        csr_data = data;
        tlb_d_valid = 1'b1;
        @(negedge clk);
        check_value("csr wait wb_we0", 32'd0, wb_we0);
        check_value("csr wait allowin", 32'd0, ex2_allowin);
        csr_ready = 1'b1;
        wait_lane0_strobe("csr");
        check_value("csr wb_data0", data, wb_data0);
        check_value("csr ready allowin", 32'd1, ex2_allowin);
        clear_lanes();
        @(negedge clk);
        check_value("csr readback", data, rf_rdata0);
        inst0 = $urandom | 1;
        uop0 = wb_pkg::uop_t'((1 << `UOP_INS_MEM) | (1 << `UOP_COND_STORE));
        rd0 = rd_c;
        dcache_data = $urandom;
        tlb_d_valid = 1'b1;
        dcache_ready = 1'b1;
        @(negedge clk);
        check_value("store wb_we0", 32'd0, wb_we0);
        check_value("store allowin", 32'd1, ex2_allowin);
        clear_lanes();
        @(negedge clk);
        check_value("store keeps rd", data, rf_rdata0);
    endtask

    task automatic source_priority();
        wb_pkg::uop_t  div;
        wb_pkg::uop_t  csr;
        wb_pkg::word_t da;
        wb_pkg::word_t db;
        div = wb_pkg::uop_t'((1 << `UOP_INS_DIV) | (1 << `UOP_COND_REM));
        csr = wb_pkg::uop_t'(1 << `UOP_INS_CSR);
        da = $urandom;
        db = $urandom;
        issue_pair("priority div", div, div, 5'd3, 5'd4, da, db, da, db);
        csr_data = $urandom;
        csr_ready = 1'b1;
        issue_pair("priority csr", csr, div, 5'd5, 5'd6, db, da, db, da);
    endtask

    task automatic exception_commit();
        wb_pkg::ecode_t codes [10];
        wb_pkg::ecode_t code;
        logic           exp_badv;
        logic           exp_vppn;
        logic           exp_tlb;
        string          tag;
        codes = '{`EXP_INT, `EXP_PIL, `EXP_PIS, `EXP_PIF, `EXP_PME,
                  `EXP_PPI, `EXP_ADEF, `EXP_ALE, `EXP_SYS, `EXP_TLBR};
        foreach (codes[i]) begin
            code = codes[i];
            tag = $sformatf("exception 0x%02h", code);
            exp_badv = code inside {`EXP_PIL, `EXP_PIS, `EXP_PIF, `EXP_PME, `EXP_PPI,
                                    `EXP_ADEF, `EXP_ALE, `EXP_TLBR};
            exp_vppn = code inside {`EXP_PIL, `EXP_PIS, `EXP_PIF, `EXP_PME, `EXP_PPI,
                                    `EXP_TLBR};
            exp_tlb = (code == `EXP_TLBR);
            badv = $urandom;
            era = $urandom;
            eentry = $urandom;
            tlbrentry = $urandom;
            ecode = code;
            exception_flag = 1'b1;
            @(negedge clk);
            check_value({tag, " flush"}, 32'd1, flush);
            check_value({tag, " wen_era"}, 32'd1, wen_era);
            check_value({tag, " wen_badv"}, exp_badv, wen_badv);
            check_value({tag, " wen_vppn"}, exp_vppn, wen_vppn);
            check_value({tag, " tlb_exception"}, exp_tlb, tlb_exception);
            check_value({tag, " pc_from_wb"}, exp_tlb ? tlbrentry : eentry, pc_from_wb);
            check_value({tag, " badv_out"}, badv, badv_out);
            check_value({tag, " era_out"}, era, era_out);
            check_value({tag, " vppn_out"}, badv[`WB_VPPN_BITS-1:0], vppn_out);
            exception_flag = 1'b0;
            @(negedge clk);
            check_value({tag, " flush drop"}, 32'd0, flush);
        end
        // interrupt with a stale address code
        ecode = `EXP_PIL;
        cpu_interrupt = 1'b1;
        @(negedge clk);
        check_value("interrupt flush", 32'd1, flush);
        check_value("interrupt wen_era", 32'd1, wen_era);
        check_value("interrupt wen_badv", 32'd0, wen_badv);
        check_value("interrupt wen_vppn", 32'd0, wen_vppn);
        check_value("interrupt pc_from_wb", eentry, pc_from_wb);
        clear_lanes();
        @(negedge clk);
    endtask

    initial begin
        void'($urandom(SEED));
        errors = 0;
        checks = 0;
        aresetn = 1'b0;
        clear_lanes();
        rf_raddr0 = '0;
        rf_raddr1 = '0;
        dcache_data = '0;
        csr_data = '0;
        div_dividend = '0;
        div_divisor = '0;
        ecode = '0;
        badv = '0;
        era = '0;
        eentry = '0;
        tlbrentry = '0;
        repeat (2) @(negedge clk);
        aresetn = 1'b1;
        alu_writeback();
        division();
        load_and_csr();
        source_priority();
        exception_commit();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: wb_commit.f
+incdir+src
src/wb_pkg.sv
src/div_unit.sv
src/wb_select.sv
src/wb_exception.sv
src/regfile.sv
src/wb_top.sv
tests/tb_clock.sv
tests/wb_top_properties.sv
tests/wb_top_tb.sv
